/* test/mul_vectors.txt */
// Columns: flush valid is_signed high tag a b expected, all hex, one line per cycle
// Expected is the returned product half, ignored for idle and flushed lines
// Idle after reset
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000
// Unsigned low and high halves with bubbles
0 1 0 0 1 0003 0005 000f
0 0 0 0 0 0000 0000 0000
0 1 0 1 2 ffff ffff fffe
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000
0 1 0 0 3 1234 0010 2340
0 1 0 1 4 1234 0010 0001
0 0 0 0 0 0000 0000 0000
0 1 0 0 5 00ff 0101 ffff
0 1 0 1 6 8000 0002 0001
// Signed, back to back, negative and minimum operands
0 1 1 0 7 ffff 0003 fffd
0 1 1 1 8 ffff 0003 ffff
0 1 1 1 9 8000 8000 4000
0 1 1 0 a 8000 8000 0000
0 1 1 1 b 8000 7fff c000
0 1 1 0 c 8000 7fff 8000
0 1 1 0 d fffe 0005 fff6
0 1 1 1 e ffff ffff 0000
0 1 1 1 f 7fff 7fff 3fff
// Bubble pattern one, two
0 1 0 0 0 0007 0009 003f
0 0 0 0 0 0000 0000 0000
0 1 0 1 1 abcd 0100 00ab
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000
0 1 0 0 2 abcd 0100 cd00
// Flush with three operations in flight, then normal issues
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000
0 1 1 0 3 0002 0002 0004
0 1 0 1 4 ffff 0002 0001
1 1 0 0 5 0003 0003 0009
0 1 0 0 6 0006 0007 002a
0 1 1 0 7 ffff 8000 8000
0 1 0 0 8 0011 0011 0121
0 0 0 0 0 0000 0000 0000
0 0 0 0 0 0000 0000 0000

/* verilog.f */
src/mul_pkg.sv
src/modn_counter.sv
src/fifo_nohs.sv
src/mul_datapath.sv
src/mul_result_select.sv
src/mul_unit.sv
test/tb_clock_gen.sv
test/tb_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mul_unit \
  -f verilog.f \
  -o sim_mul_unit \
  && ./obj_dir/sim_mul_unit \
  || exit 1

/* test/tb_mul_unit.sv */
// Multiply unit testbench replaying file vectors and seeded random issues against a queue
module tb_mul_unit;
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------------------------------------
  // Limits and vector memory layout
  // --------------------------------------------------

  localparam int unsigned FIELDS        = 8;
  localparam int unsigned MAX_LINES     = 64;
  localparam int unsigned VEC_WORDS     = MAX_LINES * FIELDS;
  localparam int unsigned RAND_OPS      = 12;
  localparam int unsigned RESET_TIMEOUT = 50;
  localparam int unsigned DRAIN_TIMEOUT = 20;
  localparam int unsigned IDLE_TAIL     = 4;

  // Falling edges from drive to a visible result
  localparam int unsigned LATENCY = mul_pkg::MUL_LATENCY + 1;

  // One outstanding result
  typedef struct packed {
    logic [mul_pkg::TAG_W-1:0]     tag;
    logic [mul_pkg::OPERAND_W-1:0] value;
    logic [31:0]                   due;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             flush;
  mul_pkg::issue_t  issue;
  mul_pkg::result_t result;

  logic [15:0] vec_mem [VEC_WORDS];
  expect_t     exp_q [$];
  logic [31:0] cycle_cnt = '0;

  tb_clock_gen clock_gen_inst (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  mul_unit mul_unit_inst (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .flush_i (flush),
    .issue_i (issue),
    .result_o(result)
  );

  // Edge count, read only on falling edges
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_with_failure("result check failed");
    end
  endtask

  // Extend both operands to 64 bits, multiply, pick the half
  function automatic logic [15:0] product_half(input mul_pkg::issue_t op);
    logic [63:0] a_wide;
    logic [63:0] b_wide;
    logic [63:0] full;
    a_wide = op.is_signed ? {{48{op.a[15]}}, op.a} : {48'b0, op.a};
    b_wide = op.is_signed ? {{48{op.b[15]}}, op.b} : {48'b0, op.b};
    full = a_wide * b_wide;
    return op.high ? full[31:16] : full[15:0];
  endfunction

  // Result due now must be the queue head, otherwise valid stays low
  task automatic check_output();
    logic exp_valid;
    exp_valid = (exp_q.size() != 0) && (exp_q[0].due == cycle_cnt);
    check_equal("result_o.valid", 32'(result.valid), 32'(exp_valid));
    if (exp_valid) begin
      check_equal("result_o.tag", 32'(result.tag), 32'(exp_q[0].tag));
      check_equal("result_o.value", 32'(result.value), 32'(exp_q[0].value));
      void'(exp_q.pop_front());
    end
  endtask

  // Anything not yet in the result register at the flush edge is lost
  task automatic drop_flushed();
    while ((exp_q.size() != 0) && (exp_q[exp_q.size() - 1].due > cycle_cnt + 1)) begin
      void'(exp_q.pop_back());
    end
  endtask

  // One falling edge, check first, then drive the next inputs
  task automatic step_cycle(input logic flush_v, input mul_pkg::issue_t op,
                            input logic [15:0] exp_value);
    expect_t entry;
    @(negedge clk);
    check_output();
    flush = flush_v;
    issue = op;
    if (flush_v) begin
      drop_flushed();
    end else if (op.valid) begin
      entry.tag   = op.tag;
      entry.value = exp_value;
      entry.due   = cycle_cnt + LATENCY;
      exp_q.push_back(entry);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    mul_pkg::issue_t op;
    int              seed;
    int unsigned     line_idx;
    int unsigned     base;
    int unsigned     wait_cnt;
    logic [31:0]     rnd_ops;
    logic [31:0]     rnd_ctl;

    flush = 1'b0;
    issue = '0;
    seed = 74;

    // Unwritten words never read as a flush value of 0 or 1
    for (int k = 0; k < VEC_WORDS; k++) begin
      vec_mem[k] = ~(16'(k));
    end
    $readmemh("test/mul_vectors.txt", vec_mem);

    // Reset may still be unknown at time zero
    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > RESET_TIMEOUT) begin
        stop_with_failure("timed out waiting for reset release");
      end
    end

    // File vectors, end at the first unwritten line
    line_idx = 0;
    base = 0;
    while ((line_idx < MAX_LINES) && (vec_mem[base] <= 16'h1)) begin
      op.valid     = vec_mem[base + 1][0];
      op.is_signed = vec_mem[base + 2][0];
      op.high      = vec_mem[base + 3][0];
      op.tag       = vec_mem[base + 4][mul_pkg::TAG_W-1:0];
      op.a         = vec_mem[base + 5];
      op.b         = vec_mem[base + 6];
      step_cycle(vec_mem[base][0], op, vec_mem[base + 7]);
      line_idx++;
      base = line_idx * FIELDS;
    end

    // Seeded back-to-back random operations
    for (int n = 0; n < RAND_OPS; n++) begin
      rnd_ops = $random(seed);
      rnd_ctl = $random(seed);
      op.valid     = 1'b1;
      op.is_signed = rnd_ctl[0];
      op.high      = rnd_ctl[1];
      op.tag       = rnd_ctl[7:4];
      op.a         = rnd_ops[15:0];
      op.b         = rnd_ops[31:16];
      step_cycle(1'b0, op, product_half(op));
    end

    // Drain, then a few idle edges with no stray results
    wait_cnt = 0;
    while (exp_q.size() != 0) begin
      step_cycle(1'b0, '0, '0);
      wait_cnt++;
      if (wait_cnt > DRAIN_TIMEOUT) begin
        stop_with_failure("timed out waiting for pending results");
      end
    end
    repeat (IDLE_TAIL) step_cycle(1'b0, '0, '0);

    if (exp_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      stop_with_failure("results still pending at the end of the run");
    end
  end

endmodule

/* test/tb_clock_gen.sv */
// Testbench clock and reset source, 10 ns clock with reset held for 10 cycles
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half of the 10 ns period
  localparam int unsigned HALF_PERIOD_NS = 5;

  // Rising edges seen while reset is low
  localparam int unsigned RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* src/mul_unit.sv */
// Pipelined multiply unit top joining the datapath, metadata FIFO and result selector
module mul_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  mul_pkg::issue_t  issue_i,
  output mul_pkg::result_t result_o
);

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------

  // Metadata pushed at issue
  mul_pkg::meta_t issue_meta;

  // Metadata at the FIFO head
  mul_pkg::meta_t head_meta;

  // Datapath product
  mul_pkg::prod_t prod;

  // Pop strobe from the selector
  logic meta_pop;

  assign issue_meta.high = issue_i.high;
  assign issue_meta.tag  = issue_i.tag;

  // --------------------------------------------------
  // Instances
  // --------------------------------------------------

  // Operands go down the multiplier
  mul_datapath mul_datapath_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .issue_i(issue_i),
    .prod_o (prod)
  );

  // Tag and half select wait here, same order as the datapath
  fifo_nohs #(
    .DATA_T(mul_pkg::meta_t),
    .DEPTH (mul_pkg::FIFO_DEPTH)
  ) meta_fifo_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .push_i (issue_i.valid),
    .pop_i  (meta_pop),
    .data_i (issue_meta),
    .data_o (head_meta)
  );

  // Joins product and metadata
  mul_result_select mul_result_select_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .prod_i  (prod),
    .meta_i  (head_meta),
    .pop_o   (meta_pop),
    .result_o(result_o)
  );

endmodule

/* src/mul_result_select.sv */
// Result selector pairing each product with its metadata and registering the tagged half
module mul_result_select (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  mul_pkg::prod_t   prod_i,
  input  mul_pkg::meta_t   meta_i,
  output logic             pop_o,
  output mul_pkg::result_t result_o
);

  // --------------------------------------------------
  // Metadata pop
  // --------------------------------------------------

  // FIFO head belongs to the product leaving the datapath
  assign pop_o = prod_i.valid;

  // Half picked by the parked high flag
  logic [mul_pkg::OPERAND_W-1:0] half_sel;

  assign half_sel = meta_i.high ? prod_i.product[mul_pkg::PROD_W-1:mul_pkg::OPERAND_W]
                                : prod_i.product[mul_pkg::OPERAND_W-1:0];

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  logic                          valid_q;
  logic [mul_pkg::TAG_W-1:0]     tag_q;
  logic [mul_pkg::OPERAND_W-1:0] value_q;

  // Control bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= prod_i.valid;
    end
  end

  // Payload, held while idle
  always_ff @(posedge clk_i) begin
    if (prod_i.valid) begin
      tag_q   <= meta_i.tag;
      value_q <= half_sel;
    end
  end

  assign result_o.valid = valid_q;
  assign result_o.tag   = tag_q;
  assign result_o.value = value_q;

  // Every result comes from a product one edge earlier that found written metadata
  a_result_from_prod: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    result_o.valid |-> $past(prod_i.valid && !$isunknown(meta_i))
  ) else $error("result without a preceding product and its metadata");

endmodule

/* src/mul_datapath.sv */
// Three-stage pipelined signed/unsigned 16x16 multiplier with per-stage valid and flush
module mul_datapath (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  mul_pkg::issue_t issue_i,
  output mul_pkg::prod_t  prod_o
);

  // Operand plus one extension bit
  localparam int unsigned EXT_W = mul_pkg::OPERAND_W + 1;

  // Product of two extended operands
  localparam int unsigned WIDE_W = 2 * EXT_W;

  // --------------------------------------------------
  // Stage registers
  // --------------------------------------------------

  // Valid chain
  logic s1_valid_q;
  logic s2_valid_q;
  logic s3_valid_q;

  // Stage 1, extended operands
  logic signed [EXT_W-1:0] s1_a_q;
  logic signed [EXT_W-1:0] s1_b_q;

  // Stage 2, full signed product
  logic signed [WIDE_W-1:0] s2_prod_q;

  // Stage 3, product truncated to 32 bits
  logic [mul_pkg::PROD_W-1:0] s3_prod_q;

  // Sign bit only for signed operations, zero otherwise
  logic a_ext;
  logic b_ext;

  assign a_ext = issue_i.is_signed & issue_i.a[mul_pkg::OPERAND_W-1];
  assign b_ext = issue_i.is_signed & issue_i.b[mul_pkg::OPERAND_W-1];

  // Valids shift with the data, flush empties every stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s3_valid_q <= 1'b0;
    end else if (flush_i) begin
      // Issue in the flush cycle is dropped too
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s3_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= issue_i.valid;
      s2_valid_q <= s1_valid_q;
      s3_valid_q <= s2_valid_q;
    end
  end

  // Data path, loaded only when the stage input is valid
  always_ff @(posedge clk_i) begin
    if (issue_i.valid) begin
      s1_a_q <= {a_ext, issue_i.a};
      s1_b_q <= {b_ext, issue_i.b};
    end
    if (s1_valid_q) begin
      // 17x17 signed covers both unsigned and signed 16-bit ranges
      s2_prod_q <= s1_a_q * s1_b_q;
    end
    if (s2_valid_q) begin
      s3_prod_q <= s2_prod_q[mul_pkg::PROD_W-1:0];
    end
  end

  // --------------------------------------------------
  // Output
  // --------------------------------------------------

  assign prod_o.valid   = s3_valid_q;
  assign prod_o.product = s3_prod_q;

  // An accepted issue surfaces as a product three edges later unless flushed
  a_issue_to_prod: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (issue_i.valid && !flush_i) ##1 !flush_i ##1 !flush_i |=> prod_o.valid
  ) else $error("issued operation did not reach the datapath output");

endmodule

/* src/fifo_nohs.sv */
// Handshake-free FIFO with external push and pop, overwriting the oldest entry when full
module fifo_nohs #(
  parameter type         DATA_T = logic [7:0],
  parameter int unsigned DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  DATA_T data_i,
  output DATA_T data_o
);

  if (DEPTH == 0) begin : gen_bypass
    // No storage, head is the incoming entry
    assign data_o = data_i;
  end else begin : gen_fifo
    // Pointer width, same rule as the counter
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------

    // Head points at the oldest entry, tail at the next free slot
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;

    // One valid bit per slot
    logic [DEPTH-1:0] slot_valid_q;

    // Payload slots
    DATA_T data_q [DEPTH];

    // Tail advances on push, head on pop
    modn_counter #(
      .N(DEPTH)
    ) head_cnt_inst (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .en_i   (pop_i),
      .clr_i  (flush_i),
      .count_o(head_ptr),
      .tc_o   ()
    );

    modn_counter #(
      .N(DEPTH)
    ) tail_cnt_inst (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .en_i   (push_i),
      .clr_i  (flush_i),
      .count_o(tail_ptr),
      .tc_o   ()
    );

    // --------------------------------------------------
    // Slot update
    // --------------------------------------------------

    // Valid bits, push beats pop on the same slot
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        slot_valid_q <= '0;
      end else if (flush_i) begin
        // Dropping valids empties the FIFO
        slot_valid_q <= '0;
      end else begin
        for (int i = 0; i < DEPTH; i++) begin
          if (push_i && (tail_ptr == PTR_W'(i))) begin
            slot_valid_q[i] <= 1'b1;
          end else if (pop_i && (head_ptr == PTR_W'(i))) begin
            slot_valid_q[i] <= 1'b0;
          end
        end
      end
    end

    // Payload write at the tail
    always_ff @(posedge clk_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        if (push_i && !flush_i && (tail_ptr == PTR_W'(i))) begin
          data_q[i] <= data_i;
        end
      end
    end

    // --------------------------------------------------
    // Output
    // --------------------------------------------------

    // Head entry, valid before the popping edge
    assign data_o = data_q[head_ptr];

    // Occupied tail slot means full, a push there would drop the oldest entry
    a_no_push_when_full: assert property (
      @(posedge clk_i) disable iff (!rst_ni || flush_i)
      push_i |-> !slot_valid_q[tail_ptr]
    ) else $error("push into a full FIFO");
  end

endmodule

/* src/modn_counter.sv */
// Modulo-N counter with enable, synchronous clear and terminal count flag
module modn_counter #(
  parameter int unsigned N = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                en_i,
  input  logic                                clr_i,
  output logic [((N > 1) ? $clog2(N) : 1)-1:0] count_o,
  output logic                                tc_o
);

  // Keep at least one bit for N of 1
  localparam int unsigned CNT_W = (N > 1) ? $clog2(N) : 1;

  // Last value before wrapping
  localparam logic [CNT_W-1:0] LAST = CNT_W'(N - 1);

  logic [CNT_W-1:0] cnt_q;

  // --------------------------------------------------
  // Count register
  // --------------------------------------------------

  // Clear wins over enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (en_i) begin
      // Explicit wrap, N need not be a power of two
      if (cnt_q == LAST) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign count_o = cnt_q;

  // High for the whole cycle the count sits at N-1
  assign tc_o = (cnt_q == LAST);

endmodule

/* src/mul_pkg.sv */
// Multiply unit package with shared widths, latency, FIFO depth and payload structs
package mul_pkg;

  // --------------------------------------------------
  // Widths and depths
  // --------------------------------------------------

  // Operand width of both multiplier inputs
  localparam int unsigned OPERAND_W = 16;

  // Full product width
  localparam int unsigned PROD_W = 2 * OPERAND_W;

  // Issue tag width, returned unchanged with the result
  localparam int unsigned TAG_W = 4;

  // Datapath register stages between issue and product
  localparam int unsigned MUL_LATENCY = 3;

  // One spare slot so a same-cycle push and pop never see a full FIFO
  localparam int unsigned FIFO_DEPTH = MUL_LATENCY + 1;

  // --------------------------------------------------
  // Payload structs
  // --------------------------------------------------

  // Issue port, one operation per cycle
  typedef struct packed {
    logic                 valid;
    logic                 is_signed;  // Treat a and b as two's complement
    logic                 high;       // Return product[31:16] instead of [15:0]
    logic [TAG_W-1:0]     tag;
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } issue_t;

  // Metadata parked in the FIFO while the product is computed
  typedef struct packed {
    logic             high;
    logic [TAG_W-1:0] tag;
  } meta_t;

  // Datapath output
  typedef struct packed {
    logic              valid;
    logic [PROD_W-1:0] product;
  } prod_t;

  // Unit output, tagged product half
  typedef struct packed {
    logic                 valid;
    logic [TAG_W-1:0]     tag;
    logic [OPERAND_W-1:0] value;
  } result_t;

endpackage
